// File: src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_W       32 // Data and address width
`define REG_COUNT    16 // Flat register file
`define REG_AW       4
`define OP_W         8
`define FLAG_W       3  // Eq, lt, gt
`define SP_REG       0  // Stack pointer lives in r0
`define WORD_BYTES   4  // Instruction and stack step
`define TWO_WORD_BIT 7  // Set on every opcode that carries a constant word

// Instruction word layout, only the low REG_AW bits of each register byte count
`define OP_LSB   0
`define REGA_LSB 8
`define REGB_LSB 16
`define REGC_LSB 24

// Flag bit positions
`define FLAG_EQ 0
`define FLAG_LT 1
`define FLAG_GT 2

// One-word opcodes
`define OP_MOVRR    8'h01
`define OP_ADDRRR   8'h02
`define OP_SUBRRR   8'h03
`define OP_INCR     8'h04
`define OP_DECR     8'h05
`define OP_NEGRR    8'h06
`define OP_SHLRRR   8'h07
`define OP_SHRRRR   8'h08
`define OP_CMPRR    8'h09
`define OP_CMPERRR  8'h0a
`define OP_CMPLTRRR 8'h0b
`define OP_MOVRDR   8'h0c // Load from [B]
`define OP_PUSHR    8'h0d
`define OP_POPR     8'h0e
`define OP_CALLR    8'h0f
`define OP_RET      8'h10
`define OP_DOUTR    8'h11
`define OP_STALL    8'h12

// Two-word opcodes, constant in the next word
`define OP_MOVRC    8'h81
`define OP_ADDRRC   8'h82
`define OP_SUBRRC   8'h83
`define OP_CMPRC    8'h84
`define OP_MOVDCR   8'h85 // Store B to [const]
`define OP_MOVDROR  8'h86 // Store B to [A + const]
`define OP_MOVRDC   8'h87 // Load A from [const]
`define OP_MOVRDRO  8'h88 // Load A from [B + const]
`define OP_JMPC     8'h89
`define OP_JEC      8'h8a
`define OP_JNEC     8'h8b
`define OP_JZRC     8'h8c // Tests register C
`define OP_JNZRC    8'h8d

`endif

// File: src/cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

  // Opcode is followed by a constant word
  function automatic logic isTwoWord(input logic [`OP_W-1:0] op);
    return op[`TWO_WORD_BIT];
  endfunction

  // Needs a data memory access
  function automatic logic isMemOp(input logic [`OP_W-1:0] op);
    case (op)
      `OP_MOVRDC, `OP_MOVRDR, `OP_MOVRDRO, `OP_MOVDCR, `OP_MOVDROR,
      `OP_PUSHR, `OP_POPR, `OP_CALLR, `OP_RET: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Next pointer may not be the sequential one
  function automatic logic changesIp(input logic [`OP_W-1:0] op);
    case (op)
      `OP_JMPC, `OP_JEC, `OP_JNEC, `OP_JZRC, `OP_JNZRC,
      `OP_CALLR, `OP_RET, `OP_STALL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

// File: src/cpuFetchDecode.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuFetchDecode import cpuPkg::*; (
  input  logic               clk,
  input  logic               reset,
  output logic               fetchReqValid,
  input  logic               fetchReqReady,
  output logic [`DATA_W-1:0] fetchAddr,
  input  logic               fetchRspValid,
  input  logic [`DATA_W-1:0] fetchRdata,
  input  logic               nextIpValid, // Previous instruction retired
  input  logic [`DATA_W-1:0] nextIp,
  output logic               instrValid,
  input  logic               instrReady,
  output logic [`OP_W-1:0]   opCode,
  output logic [`REG_AW-1:0] regA,
  output logic [`REG_AW-1:0] regB,
  output logic [`REG_AW-1:0] regC,
  output logic [`DATA_W-1:0] constWord,
  output logic [`DATA_W-1:0] instrIp,
  output logic               halted
);

  localparam logic [2:0] StLaunch = 3'd0; // First fetch out of reset
  localparam logic [2:0] StOpWord = 3'd1; // Waiting for the instruction word
  localparam logic [2:0] StConst  = 3'd2; // Waiting for the constant word
  localparam logic [2:0] StExec   = 3'd3; // Instruction handed on, wait for retire
  localparam logic [2:0] StHalt   = 3'd4;

  logic [2:0]         state;
  logic [`OP_W-1:0]   rspOp;

  assign rspOp = fetchRdata[`OP_LSB +: `OP_W];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state         <= StLaunch;
      fetchReqValid <= 1'b0;
      fetchAddr     <= '0;
      instrIp       <= '0;
      instrValid    <= 1'b0;
      halted        <= 1'b0;
    end else begin
      if (fetchReqValid && fetchReqReady) fetchReqValid <= 1'b0; // Request taken
      if (instrValid && instrReady) instrValid <= 1'b0;
      case (state)
        StLaunch: begin
          fetchReqValid <= 1'b1;
          fetchAddr     <= instrIp;
          state         <= StOpWord;
        end
        StOpWord: begin
          if (fetchRspValid) begin
            if (rspOp == `OP_STALL) begin
              halted <= 1'b1; // Nothing more is fetched
              state  <= StHalt;
            end else if (isTwoWord(rspOp)) begin
              fetchReqValid <= 1'b1;
              fetchAddr     <= instrIp + `WORD_BYTES;
              state         <= StConst;
            end else begin
              instrValid <= 1'b1;
              state      <= StExec;
            end
          end
        end
        StConst: begin
          if (fetchRspValid) begin
            instrValid <= 1'b1;
            state      <= StExec;
          end
        end
        StExec: begin
          if (nextIpValid) begin
            instrIp       <= nextIp;
            fetchReqValid <= 1'b1; // Next instruction word
            fetchAddr     <= nextIp;
            state         <= StOpWord;
          end
        end
        default: ; // Halted until reset
      endcase
    end
  end

  // Decoded fields
  always_ff @(posedge clk) begin
    if (state == StOpWord && fetchRspValid) begin
      opCode <= rspOp;
      regA   <= fetchRdata[`REGA_LSB +: `REG_AW];
      regB   <= fetchRdata[`REGB_LSB +: `REG_AW];
      regC   <= fetchRdata[`REGC_LSB +: `REG_AW];
    end
    if (state == StConst && fetchRspValid) constWord <= fetchRdata;
  end

endmodule

// File: src/cpuMemArbiter.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuMemArbiter (
  input  logic               clk,
  input  logic               reset,
  input  logic               fetchReqValid,
  output logic               fetchReqReady,
  input  logic [`DATA_W-1:0] fetchAddr,
  output logic               fetchRspValid,
  output logic [`DATA_W-1:0] fetchRdata,
  input  logic               dataReqValid,
  output logic               dataReqReady,
  input  logic               dataWrite,
  input  logic [`DATA_W-1:0] dataAddr,
  input  logic [`DATA_W-1:0] dataWdata,
  output logic               dataRspValid,
  output logic [`DATA_W-1:0] dataRdata,
  output logic               memReqValid,
  input  logic               memReqReady,
  output logic               memWrite,
  output logic [`DATA_W-1:0] memAddr,
  output logic [`DATA_W-1:0] memWdata,
  input  logic               memRspValid,
  input  logic [`DATA_W-1:0] memRdata
);

  localparam int TagAw = 2; // Up to four reads outstanding

  logic                lockValid; // A stalled request keeps the grant
  logic                lockData;
  logic                grantData;
  logic                memAccept;
  logic [2**TagAw-1:0] tagOwner;  // One bit per read, set for data side
  logic [TagAw-1:0]    tagWrPtr;
  logic [TagAw-1:0]    tagRdPtr;
  logic                headData;

  assign grantData     = lockValid ? lockData : dataReqValid; // Data side first
  assign memReqValid   = grantData ? dataReqValid : fetchReqValid;
  assign memWrite      = grantData & dataWrite; // Fetch only reads
  assign memAddr       = grantData ? dataAddr : fetchAddr;
  assign memWdata      = dataWdata;
  assign dataReqReady  = grantData & memReqReady;
  assign fetchReqReady = ~grantData & memReqReady;
  assign memAccept     = memReqValid & memReqReady;

  // Responses come back in order, steer by oldest tag
  assign headData      = tagOwner[tagRdPtr];
  assign dataRspValid  = memRspValid & headData;
  assign fetchRspValid = memRspValid & ~headData;
  assign dataRdata     = memRdata;
  assign fetchRdata    = memRdata;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lockValid <= 1'b0;
      lockData  <= 1'b0;
      tagWrPtr  <= '0;
      tagRdPtr  <= '0;
    end else begin
      lockValid <= memReqValid & ~memReqReady;
      lockData  <= grantData;
      if (memAccept && !memWrite) tagWrPtr <= tagWrPtr + 1'b1;
      if (memRspValid) tagRdPtr <= tagRdPtr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (memAccept && !memWrite) tagOwner[tagWrPtr] <= grantData;
  end

endmodule

// File: src/cpuExecute.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuExecute import cpuPkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               instrValid,
  output logic               instrReady,
  input  logic [`OP_W-1:0]   opCode,
  input  logic [`REG_AW-1:0] regA,
  input  logic [`REG_AW-1:0] regB,
  input  logic [`REG_AW-1:0] regC,
  input  logic [`DATA_W-1:0] constWord,
  input  logic [`DATA_W-1:0] instrIp,
  output logic [`REG_AW-1:0] rdAddrA,
  output logic [`REG_AW-1:0] rdAddrB,
  output logic [`REG_AW-1:0] rdAddrC,
  input  logic [`DATA_W-1:0] rdDataA,
  input  logic [`DATA_W-1:0] rdDataB,
  input  logic [`DATA_W-1:0] rdDataC,
  input  logic [`DATA_W-1:0] spData,
  input  logic [`FLAG_W-1:0] flagsData,
  output logic               dataReqValid,
  input  logic               dataReqReady,
  output logic               dataWrite,
  output logic [`DATA_W-1:0] dataAddr,
  output logic [`DATA_W-1:0] dataWdata,
  input  logic               dataRspValid,
  input  logic [`DATA_W-1:0] dataRdata,
  output logic               resValid,
  input  logic               resReady,
  output logic [`OP_W-1:0]   resOpCode,
  output logic [`REG_AW-1:0] resRegA,
  output logic [`DATA_W-1:0] resValue,
  output logic               resWrite,
  output logic [`FLAG_W-1:0] flagsValue,
  output logic               flagsWrite,
  output logic [`DATA_W-1:0] spValue,
  output logic               spWrite,
  output logic               jumpTaken,
  output logic [`DATA_W-1:0] jumpTarget,
  output logic [`DATA_W-1:0] resIp
);

  localparam logic [1:0] StIdle = 2'd0;
  localparam logic [1:0] StMem  = 2'd1; // Data access in flight
  localparam logic [1:0] StDone = 2'd2; // Result offered to writeback

  logic [1:0]         state;
  logic               accept;
  logic [`DATA_W-1:0] aluValue;
  logic               aluWrite;
  logic [`DATA_W-1:0] cmpRhs;
  logic [`FLAG_W-1:0] cmpFlags;
  logic [`DATA_W-1:0] memAddrNext;
  logic [`DATA_W-1:0] memDataNext;
  logic               memWriteNext;
  logic [`DATA_W-1:0] spNext;
  logic               spWriteNext;
  logic               jumpNext;

  assign rdAddrA    = regA;
  assign rdAddrB    = regB;
  assign rdAddrC    = regC;
  assign instrReady = (state == StIdle);
  assign accept     = instrValid & instrReady;

  // Register results
  always_comb begin
    aluValue = '0;
    aluWrite = 1'b1;
    case (opCode)
      `OP_MOVRR:    aluValue = rdDataB;
      `OP_MOVRC:    aluValue = constWord;
      `OP_ADDRRR:   aluValue = rdDataB + rdDataC;
      `OP_ADDRRC:   aluValue = rdDataB + constWord;
      `OP_SUBRRR:   aluValue = rdDataB - rdDataC;
      `OP_SUBRRC:   aluValue = rdDataB - constWord;
      `OP_INCR:     aluValue = rdDataA + 1'b1;
      `OP_DECR:     aluValue = rdDataA - 1'b1;
      `OP_NEGRR:    aluValue = -rdDataB;
      `OP_SHLRRR:   aluValue = rdDataB << rdDataC;
      `OP_SHRRRR:   aluValue = rdDataB >> rdDataC;
      `OP_CMPERRR:  aluValue = {{(`DATA_W-1){1'b0}}, rdDataB == rdDataC};
      `OP_CMPLTRRR: aluValue = {{(`DATA_W-1){1'b0}}, rdDataB < rdDataC}; // Unsigned
      `OP_MOVRDC, `OP_MOVRDR, `OP_MOVRDRO, `OP_POPR: aluValue = '0; // Filled by read data
      default:      aluWrite = 1'b0;
    endcase
  end

  // Flags compare A with B or with the constant
  assign cmpRhs              = (opCode == `OP_CMPRC) ? constWord : rdDataB;
  assign cmpFlags[`FLAG_EQ] = (rdDataA == cmpRhs);
  assign cmpFlags[`FLAG_LT] = (rdDataA < cmpRhs);
  assign cmpFlags[`FLAG_GT] = (rdDataA > cmpRhs);

  // Data address, store data and stack pointer
  always_comb begin
    memAddrNext  = constWord; // Absolute forms
    memDataNext  = rdDataB;
    memWriteNext = 1'b0;
    spNext       = spData;
    spWriteNext  = 1'b0;
    case (opCode)
      `OP_MOVDCR:  memWriteNext = 1'b1;
      `OP_MOVDROR: begin
        memAddrNext  = constWord + rdDataA;
        memWriteNext = 1'b1;
      end
      `OP_MOVRDR:  memAddrNext = rdDataB;
      `OP_MOVRDRO: memAddrNext = constWord + rdDataB;
      `OP_PUSHR, `OP_CALLR: begin
        memAddrNext  = spData; // Stack grows upward
        memDataNext  = (opCode == `OP_CALLR) ? instrIp : rdDataA;
        memWriteNext = 1'b1;
        spNext       = spData + `WORD_BYTES;
        spWriteNext  = 1'b1;
      end
      `OP_POPR, `OP_RET: begin
        memAddrNext = spData - `WORD_BYTES;
        spNext      = spData - `WORD_BYTES;
        spWriteNext = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (opCode)
      `OP_JMPC:  jumpNext = 1'b1;
      `OP_JEC:   jumpNext = flagsData[`FLAG_EQ];
      `OP_JNEC:  jumpNext = ~flagsData[`FLAG_EQ];
      `OP_JZRC:  jumpNext = (rdDataC == '0);
      `OP_JNZRC: jumpNext = (rdDataC != '0);
      default:   jumpNext = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= StIdle;
      dataReqValid <= 1'b0;
      resValid     <= 1'b0;
    end else begin
      case (state)
        StIdle: begin
          if (accept && isMemOp(opCode)) begin
            dataReqValid <= 1'b1;
            state        <= StMem;
          end else if (accept) begin
            resValid <= 1'b1; // ALU ops finish next cycle
            state    <= StDone;
          end
        end
        StMem: begin
          if (dataReqValid && dataReqReady) begin
            dataReqValid <= 1'b0;
            if (dataWrite) begin
              resValid <= 1'b1; // No response for writes
              state    <= StDone;
            end
          end
          if (dataRspValid) begin
            resValid <= 1'b1;
            state    <= StDone;
          end
        end
        default: begin
          if (resReady) begin
            resValid <= 1'b0;
            state    <= StIdle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      resOpCode  <= opCode;
      resRegA    <= regA;
      resIp      <= instrIp;
      resValue   <= aluValue;
      resWrite   <= aluWrite;
      flagsValue <= cmpFlags;
      flagsWrite <= (opCode == `OP_CMPRR) || (opCode == `OP_CMPRC);
      spValue    <= spNext;
      spWrite    <= spWriteNext;
      jumpTaken  <= jumpNext;
      jumpTarget <= constWord;
      dataWrite  <= memWriteNext;
      dataAddr   <= memAddrNext;
      dataWdata  <= memDataNext;
    end
    if (state == StMem && dataRspValid) resValue <= dataRdata; // Load, pop, ret
  end

endmodule

// File: src/cpuWriteback.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuWriteback import cpuPkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               resValid,
  output logic               resReady,
  input  logic [`OP_W-1:0]   opCode,
  input  logic [`REG_AW-1:0] regA,
  input  logic [`DATA_W-1:0] resValue,
  input  logic               resWrite,
  input  logic [`FLAG_W-1:0] flagsValue,
  input  logic               flagsWrite,
  input  logic [`DATA_W-1:0] spValue,
  input  logic               spWrite,
  input  logic               jumpTaken,
  input  logic [`DATA_W-1:0] jumpTarget,
  input  logic [`DATA_W-1:0] instrIp,
  input  logic [`REG_AW-1:0] rdAddrA,
  input  logic [`REG_AW-1:0] rdAddrB,
  input  logic [`REG_AW-1:0] rdAddrC,
  output logic [`DATA_W-1:0] rdDataA,
  output logic [`DATA_W-1:0] rdDataB,
  output logic [`DATA_W-1:0] rdDataC,
  output logic [`DATA_W-1:0] spData,
  output logic [`FLAG_W-1:0] flagsData,
  output logic               nextIpValid,
  output logic [`DATA_W-1:0] nextIp,
  output logic               doutValid,
  output logic [`DATA_W-1:0] doutData
);

  logic [`DATA_W-1:0] regFile [`REG_COUNT];
  logic [`FLAG_W-1:0] flags;
  logic               retire;
  logic [`DATA_W-1:0] regAValue;
  logic [`DATA_W-1:0] seqIp;

  assign resReady  = 1'b1; // Every result retires in its first cycle
  assign retire    = resValid & resReady;

  assign rdDataA   = regFile[rdAddrA];
  assign rdDataB   = regFile[rdAddrB];
  assign rdDataC   = regFile[rdAddrC];
  assign spData    = regFile[`SP_REG];
  assign flagsData = flags;
  assign regAValue = regFile[regA];

  // Step over the constant word too
  assign seqIp = instrIp + (isTwoWord(opCode) ? 2 * `WORD_BYTES : `WORD_BYTES);

  always_comb begin
    nextIp = seqIp; // Also untaken branches
    if (changesIp(opCode)) begin
      if (jumpTaken) nextIp = jumpTarget;
      else if (opCode == `OP_RET) nextIp = resValue + `WORD_BYTES; // Past the call
      else if (opCode == `OP_CALLR) nextIp = regAValue;
    end
  end

  assign nextIpValid = retire;
  assign doutValid   = retire & (opCode == `OP_DOUTR);
  assign doutData    = regAValue;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regFile[i] <= '0;
      end
      flags <= '0;
    end else if (retire) begin
      if (resWrite) regFile[regA] <= resValue;
      if (spWrite) regFile[`SP_REG] <= spValue; // Stack update wins on pop into r0
      if (flagsWrite) flags <= flagsValue;
    end
  end

endmodule

// File: src/cpuTop.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuTop (
  input  logic               clk,
  input  logic               reset,
  output logic               memReqValid,
  input  logic               memReqReady,
  output logic               memWrite,
  output logic [`DATA_W-1:0] memAddr,
  output logic [`DATA_W-1:0] memWdata,
  input  logic               memRspValid,
  input  logic [`DATA_W-1:0] memRdata,
  output logic               doutValid, // DoutR retired
  output logic [`DATA_W-1:0] doutData,
  output logic               halted
);

  // Fetch to arbiter
  logic               fetchReqValid, fetchReqReady, fetchRspValid;
  logic [`DATA_W-1:0] fetchAddr, fetchRdata;
  // Execute to arbiter
  logic               dataReqValid, dataReqReady, dataWrite, dataRspValid;
  logic [`DATA_W-1:0] dataAddr, dataWdata, dataRdata;
  // Fetch to execute
  logic               instrValid, instrReady;
  logic [`OP_W-1:0]   opCode;
  logic [`REG_AW-1:0] regA, regB, regC;
  logic [`DATA_W-1:0] constWord, instrIp;
  // Register reads
  logic [`REG_AW-1:0] rdAddrA, rdAddrB, rdAddrC;
  logic [`DATA_W-1:0] rdDataA, rdDataB, rdDataC, spData;
  logic [`FLAG_W-1:0] flagsData;
  // Execute to writeback
  logic               resValid, resReady, resWrite, flagsWrite, spWrite, jumpTaken;
  logic [`OP_W-1:0]   resOpCode;
  logic [`REG_AW-1:0] resRegA;
  logic [`DATA_W-1:0] resValue, spValue, jumpTarget, resIp;
  logic [`FLAG_W-1:0] flagsValue;
  // Writeback to fetch
  logic               nextIpValid;
  logic [`DATA_W-1:0] nextIp;

  cpuFetchDecode fetch0 (.*);

  cpuMemArbiter arb0 (.*);

  cpuExecute exec0 (.*);

  // Writeback sees the registered copy of the instruction fields
  cpuWriteback wb0 (
    .opCode  (resOpCode),
    .regA    (resRegA),
    .instrIp (resIp),
    .*
  );

endmodule

// File: verif/memModel.sv
`timescale 1ns/100ps

module memModel #(
  parameter int unsigned Seed = 32'h1
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        memReqValid,
  output logic        memReqReady,
  input  logic        memWrite,
  input  logic [31:0] memAddr,
  input  logic [31:0] memWdata,
  output logic        memRspValid,
  output logic [31:0] memRdata,
  output logic [31:0] lastWrAddr // Latest store address seen
);

  logic [31:0] mem [256]; // 1 KB, word index is memAddr[9:2]
  logic [31:0] rspData [$];
  int          rspDue [$]; // Cycle on which each read answers

  // Everything moves on the falling edge, request taken at the next rising edge
  initial begin
    int   cycle;
    int   lastDue;
    int   due;
    logic readyNow;
    void'($urandom(Seed));
    cycle       = 0;
    lastDue     = 0;
    memReqReady = 1'b0;
    memRspValid = 1'b0;
    memRdata    = '0;
    lastWrAddr  = '0;
    forever begin
      @(negedge clk);
      cycle++;
      memRspValid = 1'b0;
      readyNow    = ($urandom % 4) != 0; // Ready about three cycles in four
      memReqReady = readyNow;
      if (reset) begin
        rspData.delete();
        rspDue.delete();
        lastDue    = cycle;
        lastWrAddr = '0;
      end else begin
        if (rspDue.size() > 0 && rspDue[0] <= cycle) begin
          memRspValid = 1'b1; // One pulse per read, oldest first
          memRdata    = rspData.pop_front();
          void'(rspDue.pop_front());
        end
        if (memReqValid && readyNow) begin
          if (memWrite) begin
            mem[memAddr[9:2]] = memWdata; // Writes get no response
            lastWrAddr        = memAddr;
          end else begin
            due = cycle + 1 + int'($urandom % 4); // 0 to 3 extra cycles
            if (due <= lastDue) due = lastDue + 1; // Keep order
            lastDue = due;
            rspData.push_back(mem[memAddr[9:2]]);
            rspDue.push_back(due);
          end
        end
      end
    end
  end

endmodule

// File: verif/cpuTb.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuTb;

  localparam int unsigned RandSeed = 32'hd6a844b4;
  localparam int NumTests      = 5;
  localparam int MaxWords      = 40;
  localparam int MaxOuts       = 12;
  localparam int ResetCycles   = 10;
  localparam int SettleCycles  = 20; // Quiet time after halt
  localparam int CyclesPerWord = 40; // Cycle budget per program word

  logic        clk;
  logic        reset;
  logic        memReqValid, memReqReady, memWrite, memRspValid;
  logic [31:0] memAddr, memWdata, memRdata;
  logic        doutValid, halted;
  logic [31:0] doutData, lastWrAddr;

  // Test table
  string       testName  [NumTests];
  logic [31:0] progWord  [NumTests][MaxWords];
  int          progLen   [NumTests];
  logic [31:0] expOut    [NumTests][MaxOuts];
  int          expCount  [NumTests];
  logic        expHalted [NumTests];
  logic [31:0] expLastWr [NumTests];

  int          nBuilt;      // Rows filled so far
  int          curTest;
  int          errors;
  int          badTests;
  bit          tableReady;
  logic [31:0] gotOut [$];  // doutData of the running test

  cpuTop dut0 (.*);

  memModel #(.Seed(RandSeed)) mem0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] encode(input logic [7:0] op, input int a, input int b,
                                         input int c);
    return {4'h0, c[3:0], 4'h0, b[3:0], 4'h0, a[3:0], op};
  endfunction

  // Background memory contents distinct per word
  function automatic logic [31:0] fillWord(input int idx);
    return 32'h5eed0000 + idx * 4;
  endfunction

  task automatic startTest(input string name);
    testName[nBuilt]  = name;
    progLen[nBuilt]   = 0;
    expCount[nBuilt]  = 0;
    expHalted[nBuilt] = 1'b1;
    expLastWr[nBuilt] = '0; // No store
  endtask

  task automatic addWord(input logic [31:0] w);
    progWord[nBuilt][progLen[nBuilt]] = w;
    progLen[nBuilt]++;
  endtask

  task automatic oneWord(input logic [7:0] op, input int a, input int b, input int c);
    addWord(encode(op, a, b, c));
  endtask

  task automatic withConst(input logic [7:0] op, input int a, input int b,
                           input logic [31:0] k);
    addWord(encode(op, a, b, 0));
    addWord(k);
  endtask

  // Target is the word after the next one-word instruction
  task automatic jumpOverNext(input logic [7:0] op, input int c);
    int target;
    target = (progLen[nBuilt] + 3) * 4;
    addWord(encode(op, 0, 0, c));
    addWord(target);
  endtask

  task automatic printReg(input int r);
    oneWord(`OP_DOUTR, r, 0, 0);
  endtask

  task automatic stopCore();
    oneWord(`OP_STALL, 0, 0, 0);
  endtask

  task automatic expectOut(input logic [31:0] v);
    expOut[nBuilt][expCount[nBuilt]] = v;
    expCount[nBuilt]++;
  endtask

  // Wait one cycle and record a retired DoutR
  task automatic recordCycle();
    @(negedge clk);
    if (doutValid) gotOut.push_back(doutData);
  endtask

  task automatic buildTable();
    int subAddr;
    int loopAddr;
    nBuilt = 0;
    startTest("arith");
    withConst(`OP_MOVRC, 1, 0, 7);
    withConst(`OP_MOVRC, 2, 0, 9);
    withConst(`OP_MOVRC, 8, 0, 3);
    oneWord(`OP_ADDRRR, 3, 1, 2);
    printReg(3);
    expectOut(32'd7 + 32'd9);
    oneWord(`OP_SUBRRR, 4, 1, 2);
    printReg(4);
    expectOut(32'd7 - 32'd9);
    withConst(`OP_ADDRRC, 5, 4, 5);
    printReg(5);
    expectOut(32'd7 - 32'd9 + 32'd5);
    withConst(`OP_SUBRRC, 6, 1, 10);
    printReg(6);
    expectOut(32'd7 - 32'd10);
    oneWord(`OP_INCR, 2, 0, 0);
    printReg(2);
    expectOut(32'd9 + 32'd1);
    oneWord(`OP_DECR, 1, 0, 0);
    printReg(1);
    expectOut(32'd7 - 32'd1);
    oneWord(`OP_NEGRR, 7, 1, 0);
    printReg(7);
    expectOut(32'd0 - 32'd6);
    oneWord(`OP_SHLRRR, 9, 2, 8);
    printReg(9);
    expectOut(32'd10 << 3);
    oneWord(`OP_SHRRRR, 10, 4, 8);
    printReg(10);
    expectOut((32'd7 - 32'd9) >> 3);
    oneWord(`OP_MOVRR, 11, 3, 0);
    printReg(11);
    expectOut(32'd16);
    stopCore();
    nBuilt++;
    startTest("compare");
    withConst(`OP_MOVRC, 1, 0, 5);
    withConst(`OP_MOVRC, 2, 0, 5);
    withConst(`OP_MOVRC, 3, 0, 8);
    oneWord(`OP_CMPERRR, 4, 1, 2);
    printReg(4);
    expectOut(32'd1); // 5 == 5
    oneWord(`OP_CMPLTRRR, 5, 3, 1);
    printReg(5);
    expectOut(32'd0); // 8 < 5
    oneWord(`OP_CMPLTRRR, 6, 1, 3);
    printReg(6);
    expectOut(32'd1);
    oneWord(`OP_CMPRR, 1, 2, 0);
    jumpOverNext(`OP_JNEC, 0);
    printReg(1);
    expectOut(32'd5);
    withConst(`OP_CMPRC, 1, 0, 6);
    jumpOverNext(`OP_JEC, 0);
    printReg(3);
    expectOut(32'd8);
    withConst(`OP_CMPRC, 3, 0, 8);
    jumpOverNext(`OP_JEC, 0);
    printReg(2); // Skipped
    oneWord(`OP_CMPRR, 1, 3, 0);
    jumpOverNext(`OP_JNEC, 0);
    printReg(1); // Skipped
    printReg(2);
    expectOut(32'd5);
    stopCore();
    nBuilt++;
    startTest("loadstore");
    withConst(`OP_MOVRC, 1, 0, 32'h12345678);
    withConst(`OP_MOVRC, 2, 0, 32'h200);
    withConst(`OP_MOVRC, 3, 0, 32'hcafe0001);
    withConst(`OP_MOVDCR, 0, 1, 32'h240);  // Absolute store
    withConst(`OP_MOVDROR, 2, 3, 32'h10);  // Lands at 0x210
    withConst(`OP_MOVRDC, 4, 0, 32'h240);
    printReg(4);
    expectOut(32'h12345678);
    withConst(`OP_MOVRC, 5, 0, 32'h210);
    oneWord(`OP_MOVRDR, 6, 5, 0);
    printReg(6);
    expectOut(32'hcafe0001);
    withConst(`OP_MOVRDRO, 7, 2, 32'h40);
    printReg(7);
    expectOut(32'h12345678);
    withConst(`OP_MOVRDC, 8, 0, 32'h300);
    printReg(8);
    expectOut(fillWord(32'h300 / 4));
    stopCore();
    expLastWr[nBuilt] = 32'h210;
    nBuilt++;
    startTest("stack");
    withConst(`OP_MOVRC, 0, 0, 32'h380); // Stack above the program
    withConst(`OP_MOVRC, 1, 0, 11);
    withConst(`OP_MOVRC, 2, 0, 22);
    withConst(`OP_MOVRC, 3, 0, 33);
    oneWord(`OP_PUSHR, 1, 0, 0);
    oneWord(`OP_PUSHR, 2, 0, 0);
    oneWord(`OP_PUSHR, 3, 0, 0);
    oneWord(`OP_POPR, 4, 0, 0);
    printReg(4);
    expectOut(32'd33);
    oneWord(`OP_POPR, 5, 0, 0);
    printReg(5);
    expectOut(32'd22);
    oneWord(`OP_POPR, 6, 0, 0);
    printReg(6);
    expectOut(32'd11);
    subAddr = (progLen[nBuilt] + 5) * 4; // Past call, print and stall
    withConst(`OP_MOVRC, 7, 0, subAddr);
    oneWord(`OP_CALLR, 7, 0, 0);
    printReg(0);
    stopCore();
    withConst(`OP_MOVRC, 9, 0, 32'h77);
    printReg(9);
    expectOut(32'h77);
    oneWord(`OP_RET, 0, 0, 0);
    expectOut(32'h380); // Pointer back at its base after return
    expLastWr[nBuilt] = 32'h380;
    nBuilt++;
    startTest("loop");
    withConst(`OP_MOVRC, 1, 0, 3); // Counter
    withConst(`OP_MOVRC, 2, 0, 0);
    loopAddr = progLen[nBuilt] * 4;
    withConst(`OP_ADDRRC, 2, 2, 10);
    printReg(2);
    oneWord(`OP_DECR, 1, 0, 0);
    withConst(`OP_JNZRC, 0, 0, loopAddr);
    progWord[nBuilt][progLen[nBuilt] - 2] = encode(`OP_JNZRC, 0, 0, 1); // Tests r1
    for (int n = 1; n <= 3; n++) expectOut(n * 10);
    jumpOverNext(`OP_JZRC, 1);
    printReg(1); // Skipped since the counter is zero
    withConst(`OP_MOVRC, 3, 0, 2);
    jumpOverNext(`OP_JZRC, 3);
    printReg(3);
    expectOut(32'd2);
    jumpOverNext(`OP_JMPC, 0);
    printReg(2);
    stopCore();
    printReg(2); // Never fetched
    nBuilt++;
  endtask

  task automatic runTest(input int t);
    int   errsBefore;
    int   outsAtHalt;
    int   waited;
    logic haltedSeen;
    errsBefore = errors;
    reset = 1'b1;
    for (int i = 0; i < 256; i++) mem0.mem[i] = fillWord(i);
    for (int i = 0; i < progLen[t]; i++) mem0.mem[i] = progWord[t][i];
    repeat (ResetCycles) @(negedge clk);
    gotOut.delete();
    reset = 1'b0;
    waited = 0;
    while (!halted && waited < progLen[t] * CyclesPerWord) begin
      recordCycle();
      waited++;
    end
    haltedSeen = halted;
    outsAtHalt = gotOut.size();
    repeat (SettleCycles) recordCycle();
    assert (gotOut.size() == expCount[t]) else begin
      $display("FAILED %s: output count expected %0d actual %0d", testName[t],
               expCount[t], gotOut.size());
      errors++;
    end
    for (int i = 0; i < expCount[t] && i < gotOut.size(); i++) begin
      assert (gotOut[i] == expOut[t][i]) else begin
        $display("FAILED %s: output %0d expected %h actual %h", testName[t], i,
                 expOut[t][i], gotOut[i]);
        errors++;
      end
    end
    assert (haltedSeen == expHalted[t]) else begin
      $display("FAILED %s: halted expected %b actual %b", testName[t], expHalted[t],
               haltedSeen);
      errors++;
    end
    if (haltedSeen) begin
      assert (gotOut.size() == outsAtHalt) else begin
        $display("ERROR %s: doutValid pulsed after the core had halted", testName[t]);
        errors++;
      end
    end
    assert (lastWrAddr == expLastWr[t]) else begin
      $display("FAILED %s: last write address expected %h actual %h", testName[t],
               expLastWr[t], lastWrAddr);
      errors++;
    end
    if (errors != errsBefore) badTests++;
    $display("test %0d %s: %s", t, testName[t], (errors == errsBefore) ? "ok" : "failed");
  endtask

  initial begin
    reset      = 1'b1;
    errors     = 0;
    badTests   = 0;
    curTest    = 0;
    tableReady = 1'b0;
    buildTable();
    tableReady = 1'b1;
    for (int t = 0; t < NumTests; t++) begin
      curTest = t;
      runTest(t);
    end
    $display("%0d tests run, %0d ok, %0d with errors, %0d checks wrong", NumTests,
             NumTests - badTests, badTests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Budget scales with the longest program
  initial begin
    int maxLen;
    int limit;
    wait (tableReady);
    maxLen = 0;
    for (int t = 0; t < NumTests; t++) begin
      if (progLen[t] > maxLen) maxLen = progLen[t];
    end
    limit = NumTests * (maxLen * CyclesPerWord + ResetCycles + SettleCycles);
    repeat (limit) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, test %s never halted", limit,
             testName[curTest]);
    $display("tests failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+src
src/cpuPkg.sv
src/cpuFetchDecode.sv
src/cpuMemArbiter.sv
src/cpuExecute.sv
src/cpuWriteback.sv
src/cpuTop.sv
verif/memModel.sv
verif/cpuTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f vlog.f -o cpuSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/cpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  echo "Result: FAIL"
  exit 1
fi

echo "Result: PASS"
exit 0
